// File: design/cop_pkg.sv
/*
 * COP shared definitions
 * Opcodes, instruction field positions, host register map and the
 * data widths used by every block of the coprocessor
 */
package cop_pkg;

    localparam int XLEN     = 32;  // Data path width
    localparam int NREGS    = 16;  // GPRs in the register file
    localparam int RADDR_W  = 4;   // Register index width
    localparam int STRB_W   = 4;   // One enable per byte
    localparam int AXI_AW   = 8;   // Host address width
    localparam int SHAMT_W  = 5;   // Rotate amount bits
    localparam int RETIRE_W = 8;   // Retired instruction counter

    // Instruction word fields
    localparam int INSTR_OP_HI = 31;
    localparam int INSTR_OP_LO = 28;
    localparam int CRD_LSB     = 24;
    localparam int CRS1_LSB    = 20;
    localparam int CRS2_LSB    = 16;
    localparam int CRS3_LSB    = 12;

    // Host register map
    localparam logic [AXI_AW-1:0] ADDR_INSTR    = 8'h00;  // Write only
    localparam logic [AXI_AW-1:0] ADDR_STATUS   = 8'h04;
    localparam logic [AXI_AW-1:0] ADDR_WIN_BASE = 8'h40;  // 0x40..0x7C

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_XOR  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_ROTR = 4'd5,
        OP_MIX3 = 4'd6   // Three input xor
    } cop_op_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } cop_resp_t;

    typedef enum logic [1:0] {
        KIND_INSTR,   // Instruction word
        KIND_WIN_WR,  // Direct register write
        KIND_WIN_RD   // Direct register read
    } cop_kind_t;

endpackage

// File: design/cop_if.sv
/*
 * COP internal interfaces
 * cop_rf_if joins the execute unit to the register file, cop_issue_if
 * carries host accesses from the register block to the execute unit
 */
`timescale 1ns/1ps

interface cop_rf_if;
    import cop_pkg::*;

    logic               crs1_ren;    // Port 1, also serves window reads
    logic [RADDR_W-1:0] crs1_addr;
    logic [XLEN-1:0]    crs1_rdata;
    logic               crs2_ren;
    logic [RADDR_W-1:0] crs2_addr;
    logic [XLEN-1:0]    crs2_rdata;
    logic               crs3_ren;    // Mix3 only
    logic [RADDR_W-1:0] crs3_addr;
    logic [XLEN-1:0]    crs3_rdata;
    logic [STRB_W-1:0]  crd_wen;     // Byte enables, zero means no write
    logic [RADDR_W-1:0] crd_addr;
    logic [XLEN-1:0]    crd_wdata;

    modport exec (
        output crs1_ren, crs1_addr, crs2_ren, crs2_addr, crs3_ren, crs3_addr,
        output crd_wen, crd_addr, crd_wdata,
        input  crs1_rdata, crs2_rdata, crs3_rdata
    );

    modport rf (
        input  crs1_ren, crs1_addr, crs2_ren, crs2_addr, crs3_ren, crs3_addr,
        input  crd_wen, crd_addr, crd_wdata,
        output crs1_rdata, crs2_rdata, crs3_rdata
    );
endinterface

interface cop_issue_if;
    import cop_pkg::*;

    logic               valid;   // Single cycle, never stalled
    cop_kind_t          kind;
    logic [XLEN-1:0]    instr;   // Instruction word for KIND_INSTR
    logic [RADDR_W-1:0] addr;    // Window register index
    logic [XLEN-1:0]    wdata;
    logic [STRB_W-1:0]  wstrb;
    logic [XLEN-1:0]    rdata;   // Same cycle as a window read
    logic               illegal; // Pulse on a bad opcode
    logic               busy;    // Access being executed

    modport regs (
        output valid, kind, instr, addr, wdata, wstrb,
        input  rdata, illegal, busy
    );

    modport exec (
        input  valid, kind, instr, addr, wdata, wstrb,
        output rdata, illegal, busy
    );
endinterface

// File: design/cop_cprs.sv
/*
 * COP general purpose register file
 * Sixteen words, three read ports that return zero when not enabled,
 * one write port with byte enables
 */
`timescale 1ns/1ps

module cop_cprs (
    input logic g_clk,
    input logic g_resetn,
    cop_rf_if.rf rf
);
    import cop_pkg::*;

    logic [XLEN-1:0] cprs [NREGS];  // Register storage

    // Gated read ports
    always_comb begin
        rf.crs1_rdata = rf.crs1_ren ? cprs[rf.crs1_addr] : '0;
        rf.crs2_rdata = rf.crs2_ren ? cprs[rf.crs2_addr] : '0;
        rf.crs3_rdata = rf.crs3_ren ? cprs[rf.crs3_addr] : '0;
    end

    // Write port, one lane per byte enable
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < NREGS; i++) begin
                cprs[i] <= '0;
            end
        end else if (|rf.crd_wen) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (rf.crd_wen[b]) begin
                    cprs[rf.crd_addr][b*8 +: 8] <= rf.crd_wdata[b*8 +: 8];  // Lane b only
                end
            end
        end
    end

endmodule

// File: design/cop_alu.sv
/*
 * COP ALU
 * Combinational, one result from up to three operands; an opcode
 * outside the legal set yields zero
 */
`timescale 1ns/1ps

module cop_alu (
    input  cop_pkg::cop_op_t        op,
    input  logic [cop_pkg::XLEN-1:0] a,
    input  logic [cop_pkg::XLEN-1:0] b,
    input  logic [cop_pkg::XLEN-1:0] c,
    output logic [cop_pkg::XLEN-1:0] result
);
    import cop_pkg::*;

    logic [SHAMT_W-1:0] shamt;     // Rotate amount
    logic [2*XLEN-1:0]  rot_full;  // Doubled word for the rotate

    assign shamt    = b[SHAMT_W-1:0];
    assign rot_full = {a, a} >> shamt;  // Low half is a rotated right

    always_comb begin
        case (op)
            OP_ADD: begin
                result = a + b;
            end
            OP_SUB: begin
                result = a - b;
            end
            OP_XOR: begin
                result = a ^ b;
            end
            OP_AND: begin
                result = a & b;
            end
            OP_OR: begin
                result = a | b;
            end
            OP_ROTR: begin
                result = rot_full[XLEN-1:0];
            end
            OP_MIX3: begin
                result = a ^ b ^ c;  // Needs port 3
            end
            default: begin
                result = '0;  // Illegal opcode
            end
        endcase
    end

endmodule

// File: design/cop_exec.sv
/*
 * COP execute unit
 * Latches one issued access, decodes instructions and drives the
 * register file and ALU in the following cycle; window reads use
 * read port 1 in the issue cycle
 */
`timescale 1ns/1ps

module cop_exec (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    cop_issue_if.exec                iss,
    cop_rf_if.exec                   rf,
    output cop_pkg::cop_op_t         alu_op,
    output logic [cop_pkg::XLEN-1:0] alu_a,
    output logic [cop_pkg::XLEN-1:0] alu_b,
    output logic [cop_pkg::XLEN-1:0] alu_c,
    input  logic [cop_pkg::XLEN-1:0] alu_result
);
    import cop_pkg::*;

    logic               pend_valid;  // Access held for execution
    cop_kind_t          pend_kind;
    logic [XLEN-1:0]    pend_data;   // Instruction word or window data
    logic [RADDR_W-1:0] pend_addr;
    logic [STRB_W-1:0]  pend_wstrb;
    cop_op_t            dec_op;
    logic               op_legal;
    logic               do_instr;    // Legal instruction this cycle
    logic               do_win_wr;
    logic               do_win_rd;   // Window read in the issue cycle

    // Window reads are answered at once, everything else waits a cycle
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= iss.valid && (iss.kind != KIND_WIN_RD);
        end
    end

    always_ff @(posedge g_clk) begin
        if (iss.valid) begin
            pend_kind  <= iss.kind;
            pend_data  <= (iss.kind == KIND_INSTR) ? iss.instr : iss.wdata;
            pend_addr  <= iss.addr;
            pend_wstrb <= iss.wstrb;
        end
    end

    // Opcode decode
    assign dec_op = cop_op_t'(pend_data[INSTR_OP_HI:INSTR_OP_LO]);

    always_comb begin
        case (dec_op)
            OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR, OP_ROTR, OP_MIX3: op_legal = 1'b1;
            default: op_legal = 1'b0;
        endcase
    end

    assign do_instr  = pend_valid && (pend_kind == KIND_INSTR) && op_legal;
    assign do_win_wr = pend_valid && (pend_kind == KIND_WIN_WR);
    assign do_win_rd = iss.valid && (iss.kind == KIND_WIN_RD);  // Never overlaps busy

    // Read ports
    assign rf.crs1_ren  = do_win_rd || do_instr;
    assign rf.crs1_addr = do_win_rd ? iss.addr : pend_data[CRS1_LSB +: RADDR_W];
    assign rf.crs2_ren  = do_instr;
    assign rf.crs2_addr = pend_data[CRS2_LSB +: RADDR_W];
    assign rf.crs3_ren  = do_instr && (dec_op == OP_MIX3);  // Third source for mix only
    assign rf.crs3_addr = pend_data[CRS3_LSB +: RADDR_W];

    // ALU operands straight from the ports
    assign alu_op = dec_op;
    assign alu_a  = rf.crs1_rdata;
    assign alu_b  = rf.crs2_rdata;
    assign alu_c  = rf.crs3_rdata;

    // Write port
    always_comb begin
        rf.crd_wen   = '0;
        rf.crd_addr  = pend_addr;
        rf.crd_wdata = pend_data;
        if (do_instr) begin
            rf.crd_wen   = '1;  // Full word result
            rf.crd_addr  = pend_data[CRD_LSB +: RADDR_W];
            rf.crd_wdata = alu_result;
        end else if (do_win_wr) begin
            rf.crd_wen = pend_wstrb;
        end
    end

    // Back to the register block
    assign iss.rdata   = rf.crs1_rdata;
    assign iss.busy    = pend_valid;
    assign iss.illegal = pend_valid && (pend_kind == KIND_INSTR) && !op_legal;

endmodule

// File: design/cop_regs.sv
/*
 * COP host register block
 * AXI4-Lite slave with INSTR, STATUS and the sixteen word register
 * window; forwards instructions and window accesses to the execute unit
 */
`timescale 1ns/1ps

module cop_regs (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic [cop_pkg::AXI_AW-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [cop_pkg::XLEN-1:0]   wdata,
    input  logic [cop_pkg::STRB_W-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output cop_pkg::cop_resp_t         bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [cop_pkg::AXI_AW-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [cop_pkg::XLEN-1:0]   rdata,
    output cop_pkg::cop_resp_t         rresp,
    output logic                       rvalid,
    input  logic                       rready,
    cop_issue_if.regs                  iss
);
    import cop_pkg::*;

    logic                wr_hs, rd_hs;   // Handshakes this cycle
    logic                w_instr, w_status, w_win;
    logic                r_instr, r_status, r_win;
    logic                illegal_flag;   // Sticky, STATUS bit 0
    logic [RETIRE_W-1:0] retired_cnt;    // STATUS bits 15:8
    logic                instr_inflight; // INSTR issued last cycle
    logic [XLEN-1:0]     status_word;

    // Word aligned hit in 0x40..0x7C
    function automatic logic is_win(input logic [AXI_AW-1:0] a);
        return (a[AXI_AW-1:RADDR_W+2] == ADDR_WIN_BASE[AXI_AW-1:RADDR_W+2]) && (a[1:0] == 2'b00);
    endfunction

    assign w_instr  = (awaddr == ADDR_INSTR);
    assign w_status = (awaddr == ADDR_STATUS);
    assign w_win    = is_win(awaddr);
    assign r_instr  = (araddr == ADDR_INSTR);  // Reads back as zero
    assign r_status = (araddr == ADDR_STATUS);
    assign r_win    = is_win(araddr);

    // Write wins a same cycle clash so a read never sees stale data
    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign rd_hs   = arvalid && !rvalid && !iss.busy && !wr_hs;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign arready = rd_hs;

    // Issue pulse, held for exactly the handshake cycle
    assign iss.valid = (wr_hs && (w_instr || w_win)) || (rd_hs && r_win);
    assign iss.kind  = !wr_hs ? KIND_WIN_RD : (w_instr ? KIND_INSTR : KIND_WIN_WR);
    assign iss.addr  = wr_hs ? awaddr[RADDR_W+1:2] : araddr[RADDR_W+1:2];
    assign iss.instr = wdata;
    assign iss.wdata = wdata;
    assign iss.wstrb = wstrb;

    always_comb begin
        status_word                  = '0;
        status_word[0]               = illegal_flag;
        status_word[8 +: RETIRE_W]   = retired_cnt;
    end

    // STATUS
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            illegal_flag   <= 1'b0;
            retired_cnt    <= '0;
            instr_inflight <= 1'b0;
        end else begin
            instr_inflight <= wr_hs && w_instr;
            if (iss.illegal) begin
                illegal_flag <= 1'b1;  // Set beats clear
            end else if (wr_hs && w_status && wstrb[0] && wdata[0]) begin
                illegal_flag <= 1'b0;  // Write one to clear
            end
            if (instr_inflight && !iss.illegal) begin
                retired_cnt <= retired_cnt + 1'b1;  // Wraps at 256
            end
        end
    end

    // B channel
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            bvalid <= 1'b0;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (wr_hs) begin
            bresp <= (w_instr || w_status || w_win) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // R channel, data captured at the handshake
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (rd_hs) begin
            rresp <= (r_instr || r_status || r_win) ? RESP_OKAY : RESP_SLVERR;
            if (r_win) begin
                rdata <= iss.rdata;
            end else if (r_status) begin
                rdata <= status_word;
            end else begin
                rdata <= '0;  // INSTR and unmapped
            end
        end
    end

endmodule

// File: design/cop_top.sv
/*
 * COP top level
 * Host register block, execute unit, ALU and register file
 */
`timescale 1ns/1ps

module cop_top (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic [cop_pkg::AXI_AW-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [cop_pkg::XLEN-1:0]   wdata,
    input  logic [cop_pkg::STRB_W-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [cop_pkg::AXI_AW-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [cop_pkg::XLEN-1:0]   rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    import cop_pkg::*;

    cop_issue_if iss ();  // Regs to execute
    cop_rf_if    rf ();   // Execute to register file

    cop_op_t         alu_op;
    logic [XLEN-1:0] alu_a, alu_b, alu_c;
    logic [XLEN-1:0] alu_result;
    cop_resp_t       bresp_e, rresp_e;

    assign bresp = bresp_e;
    assign rresp = rresp_e;

    cop_regs regs0 (
        .g_clk   (g_clk),    .g_resetn(g_resetn),
        .awaddr  (awaddr),   .awvalid (awvalid),  .awready(awready),
        .wdata   (wdata),    .wstrb   (wstrb),    .wvalid (wvalid),   .wready(wready),
        .bresp   (bresp_e),  .bvalid  (bvalid),   .bready (bready),
        .araddr  (araddr),   .arvalid (arvalid),  .arready(arready),
        .rdata   (rdata),    .rresp   (rresp_e),  .rvalid (rvalid),   .rready(rready),
        .iss     (iss.regs)
    );

    cop_exec exec0 (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .iss       (iss.exec),
        .rf        (rf.exec),
        .alu_op    (alu_op),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_c     (alu_c),
        .alu_result(alu_result)
    );

    cop_alu alu0 (
        .op    (alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .c     (alu_c),
        .result(alu_result)
    );

    cop_cprs cprs0 (
        .g_clk   (g_clk),
        .g_resetn(g_resetn),
        .rf      (rf.rf)
    );

endmodule

// File: tests/tb_cop_axi.svh
/*
 * COP testbench helpers
 * AXI4-Lite write and read drivers, the LCG and the compare tasks
 */
`ifndef TB_COP_AXI_SVH
`define TB_COP_AXI_SVH

    // Register fill data
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // One write with bready high, returns at the negedge that sees bvalid
    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [XLEN-1:0] data,
                             input logic [STRB_W-1:0] strb, output cop_resp_t resp);
        @(negedge g_clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do begin
            @(negedge g_clk);
        end while (!bvalid);  // Handshake was on the last posedge
        resp    = cop_resp_t'(bresp);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [XLEN-1:0] data,
                            output cop_resp_t resp);
        @(negedge g_clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do begin
            @(negedge g_clk);
        end while (!rvalid);
        data    = rdata;
        resp    = cop_resp_t'(rresp);
        arvalid = 1'b0;
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %08h got %08h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input cop_resp_t exp, input cop_resp_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %s (%b) got %s (%b)", $time, name,
                     exp.name(), exp, act.name(), act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Flag in bit 0, retired count in bits 15:8, rest zero
    task automatic check_status(input logic exp_flag, input logic [RETIRE_W-1:0] exp_cnt,
                                input logic [XLEN-1:0] act);
        logic [XLEN-1:0] exp;
        exp = {16'h0000, exp_cnt, 7'h00, exp_flag};
        if (act !== exp) begin
            $display("FAIL t=%0t status expected %08h got %08h", $time, exp, act);
            abort_run();
        end
    endtask

`endif

// File: tests/tb_cop_top.sv
/*
 * COP testbench
 * Builds a table of host accesses, applies it over AXI4-Lite and
 * checks every response against a register model
 */
`timescale 1ns/1ps

module tb_cop_top;
    import cop_pkg::*;

    localparam int RESET_CYCLES     = 3;
    localparam int CYCLES_PER_ENTRY = 200;  // Watchdog budget

    typedef enum int {E_WRITE, E_INSTR, E_READ, E_STATUS, E_HOLD} entry_kind_t;

    typedef struct {
        entry_kind_t       kind;
        logic [AXI_AW-1:0] addr;
        logic [XLEN-1:0]   data;  // Write data or instruction word
        logic [STRB_W-1:0] strb;
        cop_resp_t         resp;  // Expected response
    } entry_t;

    logic                g_clk;
    logic                g_resetn;
    logic [AXI_AW-1:0]   awaddr;
    logic                awvalid, awready;
    logic [XLEN-1:0]     wdata;
    logic [STRB_W-1:0]   wstrb;
    logic                wvalid, wready;
    logic [1:0]          bresp;
    logic                bvalid, bready;
    logic [AXI_AW-1:0]   araddr;
    logic                arvalid, arready;
    logic [XLEN-1:0]     rdata;
    logic [1:0]          rresp;
    logic                rvalid, rready;

    logic [XLEN-1:0]     model [NREGS];  // Expected register contents
    logic                model_flag;
    logic [RETIRE_W-1:0] model_cnt;
    logic [31:0]         lcg_state;
    entry_t              tbl [$];
    bit                  tbl_built;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

`include "tb_cop_axi.svh"

    cop_top dut0 (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    function automatic bit op_is_legal(input logic [3:0] op);
        return op <= 4'd6;  // Add through mix3
    endfunction

    function automatic logic [XLEN-1:0] ref_alu(input logic [3:0] op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b,
                                                input logic [XLEN-1:0] c);
        logic [XLEN-1:0] r;
        int              sh;
        sh = int'(b[4:0]);
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_XOR:  r = a ^ b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_ROTR: r = (sh == 0) ? a : ((a >> sh) | (a << (XLEN - sh)));
            OP_MIX3: r = a ^ b ^ c;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old,
                                                    input logic [XLEN-1:0] wr,
                                                    input logic [STRB_W-1:0] strb);
        logic [XLEN-1:0] r;
        r = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = wr[8*b +: 8];  // Strobed lane only
            end
        end
        return r;
    endfunction

    function automatic bit in_window(input logic [AXI_AW-1:0] a);
        return (a >= 8'h40) && (a <= 8'h7c) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic [AXI_AW-1:0] win_addr(input int i);
        return ADDR_WIN_BASE + AXI_AW'(i * 4);
    endfunction

    // Opcode, crd, crs1, crs2, crs3 from the top nibble down
    function automatic logic [XLEN-1:0] mk_instr(input logic [3:0] op, input logic [3:0] rd,
                                                 input logic [3:0] s1, input logic [3:0] s2,
                                                 input logic [3:0] s3);
        return {op, rd, s1, s2, s3, 12'h000};
    endfunction

    function automatic void add_entry(input entry_kind_t kind, input logic [AXI_AW-1:0] addr,
                                      input logic [XLEN-1:0] data,
                                      input logic [STRB_W-1:0] strb, input cop_resp_t resp);
        entry_t e;
        e = '{kind, addr, data, strb, resp};
        tbl.push_back(e);
    endfunction

    function automatic void add_read_all();
        for (int i = 0; i < NREGS; i++) begin
            add_entry(E_READ, win_addr(i), '0, '0, RESP_OKAY);
        end
    endfunction

    function automatic void add_instr(input logic [XLEN-1:0] w);
        add_entry(E_INSTR, ADDR_INSTR, w, 4'hf, RESP_OKAY);
    endfunction

    function automatic void build_table();
        add_read_all();  // Everything zero out of reset
        add_entry(E_STATUS, ADDR_STATUS, '0, '0, RESP_OKAY);
        for (int i = 0; i < NREGS; i++) begin
            add_entry(E_WRITE, win_addr(i), lcg_next(), 4'hf, RESP_OKAY);
        end
        add_entry(E_WRITE, win_addr(3), lcg_next(), 4'b0101, RESP_OKAY);  // Partial strobes
        add_entry(E_WRITE, win_addr(7), lcg_next(), 4'b1000, RESP_OKAY);
        add_entry(E_WRITE, win_addr(8), lcg_next(), 4'b0010, RESP_OKAY);
        add_entry(E_WRITE, win_addr(9), lcg_next(), 4'b0000, RESP_OKAY);  // No lane at all
        add_read_all();
        add_entry(E_WRITE, win_addr(13), 32'hffff_ffe7, 4'hf, RESP_OKAY);  // Rotate by 7
        add_entry(E_WRITE, win_addr(14), 32'h0000_0020, 4'hf, RESP_OKAY);  // Rotate by 0
        add_entry(E_WRITE, win_addr(15), 32'h0000_001f, 4'hf, RESP_OKAY);  // Rotate by 31
        add_instr(mk_instr(OP_ADD, 1, 2, 3, 0));
        add_instr(mk_instr(OP_SUB, 4, 5, 6, 0));
        add_instr(mk_instr(OP_XOR, 5, 0, 1, 0));
        add_instr(mk_instr(OP_AND, 6, 7, 8, 0));
        add_instr(mk_instr(OP_OR, 10, 9, 11, 0));
        add_instr(mk_instr(OP_ROTR, 11, 12, 13, 0));
        add_instr(mk_instr(OP_ROTR, 12, 1, 14, 0));
        add_instr(mk_instr(OP_ROTR, 0, 4, 15, 0));
        add_instr(mk_instr(OP_MIX3, 9, 7, 8, 10));
        add_instr(mk_instr(OP_ADD, 2, 2, 3, 0));  // crd is also crs1
        add_entry(E_STATUS, ADDR_STATUS, '0, '0, RESP_OKAY);
        add_read_all();
        add_instr(mk_instr(4'hf, 1, 2, 3, 4));  // Illegal opcodes
        add_instr(mk_instr(4'h7, 5, 6, 7, 8));
        add_read_all();
        add_entry(E_STATUS, ADDR_STATUS, '0, '0, RESP_OKAY);
        add_entry(E_WRITE, 8'h08, 32'h0000_0001, 4'hf, RESP_SLVERR);  // Unmapped
        add_entry(E_WRITE, 8'h80, lcg_next(), 4'hf, RESP_SLVERR);
        add_entry(E_WRITE, 8'h42, lcg_next(), 4'hf, RESP_SLVERR);  // Misaligned window
        add_entry(E_READ, 8'h0c, '0, '0, RESP_SLVERR);
        add_entry(E_READ, 8'h80, '0, '0, RESP_SLVERR);
        add_entry(E_READ, 8'h7e, '0, '0, RESP_SLVERR);
        add_entry(E_STATUS, ADDR_STATUS, '0, '0, RESP_OKAY);  // Flag still set
        add_read_all();
        add_entry(E_WRITE, ADDR_STATUS, 32'h0000_0001, 4'h1, RESP_OKAY);  // Clear flag
        add_entry(E_STATUS, ADDR_STATUS, '0, '0, RESP_OKAY);
        add_entry(E_HOLD, win_addr(4), lcg_next(), 4'hf, RESP_OKAY);
        add_read_all();
        add_entry(E_STATUS, ADDR_STATUS, '0, '0, RESP_OKAY);
    endfunction

    task automatic model_instr(input logic [XLEN-1:0] w);
        if (op_is_legal(w[31:28])) begin
            model[w[27:24]] = ref_alu(w[31:28], model[w[23:20]], model[w[19:16]],
                                      model[w[15:12]]);
            model_cnt = model_cnt + 1'b1;  // Wraps at 256
        end else begin
            model_flag = 1'b1;
        end
    endtask

    // Stalls B and R while a second write and a second read wait behind them
    task automatic hold_check(input logic [AXI_AW-1:0] addr, input logic [XLEN-1:0] data);
        logic [AXI_AW-1:0] addr2;
        logic [XLEN-1:0]   data2;
        logic [XLEN-1:0]   held;
        addr2 = addr + 8'd4;
        data2 = ~data;
        @(negedge g_clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        do begin
            @(negedge g_clk);
        end while (!bvalid);
        awaddr = addr2;
        wdata  = data2;
        repeat (5) begin
            @(negedge g_clk);
            check_flag("bvalid", 1'b1, bvalid);
            check_resp("bresp", RESP_OKAY, cop_resp_t'(bresp));
            check_flag("awready", 1'b0, awready);  // Blocked by pending B
            check_flag("wready", 1'b0, wready);
        end
        bready = 1'b1;
        do begin
            @(negedge g_clk);
        end while (bvalid);
        do begin
            @(negedge g_clk);
        end while (!bvalid);  // Second write now taken
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_resp("bresp", RESP_OKAY, cop_resp_t'(bresp));
        do begin
            @(negedge g_clk);
        end while (bvalid);
        model[addr[RADDR_W+1:2]]  = data;
        model[addr2[RADDR_W+1:2]] = data2;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        do begin
            @(negedge g_clk);
        end while (!rvalid);
        held = rdata;  // arvalid stays high to probe arready
        repeat (5) begin
            @(negedge g_clk);
            check_flag("rvalid", 1'b1, rvalid);
            check_data("rdata", held, rdata);
            check_resp("rresp", RESP_OKAY, cop_resp_t'(rresp));
            check_flag("arready", 1'b0, arready);  // Blocked by pending R
        end
        check_data("rdata", model[addr[RADDR_W+1:2]], held);
        rready = 1'b1;
        do begin
            @(negedge g_clk);
        end while (rvalid);
        arvalid = 1'b0;  // Dropped before the next edge
    endtask

    task automatic apply_entry(input entry_t e);
        cop_resp_t          resp;
        logic [XLEN-1:0]    data;
        logic [RADDR_W-1:0] idx;
        idx = e.addr[RADDR_W+1:2];
        case (e.kind)
            E_WRITE: begin
                axi_write(e.addr, e.data, e.strb, resp);
                check_resp("bresp", e.resp, resp);
                if (in_window(e.addr)) begin
                    model[idx] = merge_bytes(model[idx], e.data, e.strb);
                end else if (e.addr == ADDR_STATUS && e.strb[0] && e.data[0]) begin
                    model_flag = 1'b0;  // Write one to clear
                end
            end
            E_INSTR: begin
                axi_write(ADDR_INSTR, e.data, e.strb, resp);
                check_resp("bresp", e.resp, resp);
                model_instr(e.data);
            end
            E_READ: begin
                axi_read(e.addr, data, resp);
                check_resp("rresp", e.resp, resp);
                if (in_window(e.addr)) begin
                    check_data($sformatf("rdata r%0d", idx), model[idx], data);
                end
            end
            E_STATUS: begin
                axi_read(ADDR_STATUS, data, resp);
                check_resp("rresp", e.resp, resp);
                check_status(model_flag, model_cnt, data);
            end
            default: begin
                hold_check(e.addr, e.data);
            end
        endcase
    endtask

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;  // 20 ns period
    end

    // Watchdog sized once the table exists
    initial begin
        wait (tbl_built);
        repeat (RESET_CYCLES + CYCLES_PER_ENTRY * tbl.size()) @(posedge g_clk);
        $display("Timeout: the stimulus table did not complete within its cycle budget");
        abort_run();
    end

    initial begin
        g_resetn   = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        lcg_state  = 32'h1a7905ac;
        model_flag = 1'b0;
        model_cnt  = '0;
        for (int i = 0; i < NREGS; i++) begin
            model[i] = '0;
        end
        build_table();
        tbl_built = 1'b1;
        repeat (RESET_CYCLES) @(negedge g_clk);
        g_resetn = 1'b1;
        foreach (tbl[i]) begin
            apply_entry(tbl[i]);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: sources.f
+incdir+tests
design/cop_pkg.sv
design/cop_if.sv
design/cop_cprs.sv
design/cop_alu.sv
design/cop_exec.sv
design/cop_regs.sv
design/cop_top.sv
tests/tb_cop_top.sv

// File: Makefile
# Verilator build and run for the COP testbench

TOP       ?= tb_cop_top
SRCS      ?= sources.f
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(SRCS) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(SRCS) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
